//--- dwc_rd_tests.txt
# "test <name>" opens a test; its commands follow in expected output order
# port offset id(hex) addr(hex) mst_size slv_size len beats final_addr(hex)
test eq_sizes
0 0 1 08 3 3 3 4 20

test down_aligned
0 0 2 10 3 1 1 8 1e

test unaligned_wrap
1 0 3 3b 2 1 2 5 02

test slv_gt_mst
1 0 4 20 2 4 2 3 28

test arbitration
0 0 5 00 2 1 0 2 02
1 0 6 10 1 1 1 2 12
0 1 7 21 2 0 0 3 23
1 1 8 3c 3 2 1 3 04

test queue_depth
0 0 9 00 1 0 0 2 01
0 1 a 08 2 2 1 2 0c
0 2 b 31 2 1 1 4 36
0 3 c 3e 1 0 2 6 03

//--- files.f
+incdir+.
dwc_pkg.sv
dwc_hold_if.sv
cmd_fifo.sv
cmd_arbiter.sv
dwc_hold_reg.sv
beat_splitter.sv
dwc_rd_top.sv
tb_clock.sv
dwc_rd_props.sv
dwc_rd_tb.sv

//--- dwc_rd_tb.sv
`timescale 1ns/1ps
`include "dwc_defines.svh"

module dwc_rd_tb import dwc_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 4;
  localparam int MAX_CMDS   = 32;
  localparam int MAX_TESTS  = 16;

  typedef struct packed {
    logic [`DWC_ID_W-1:0]   id;
    logic                   last;
    logic [`DWC_ADDR_W-1:0] addr;
  } beat_t;

  logic                   ACLK;
  logic                   sysReset;
  logic                   m0_cmd_valid;
  logic [`DWC_ID_W-1:0]   m0_cmd_id;
  logic [`DWC_ADDR_W-1:0] m0_cmd_addr;
  logic [`DWC_SIZE_W-1:0] m0_cmd_mst_size;
  logic [`DWC_SIZE_W-1:0] m0_cmd_slv_size;
  logic [`DWC_LEN_W-1:0]  m0_cmd_len;
  logic                   m1_cmd_valid;
  logic [`DWC_ID_W-1:0]   m1_cmd_id;
  logic [`DWC_ADDR_W-1:0] m1_cmd_addr;
  logic [`DWC_SIZE_W-1:0] m1_cmd_mst_size;
  logic [`DWC_SIZE_W-1:0] m1_cmd_slv_size;
  logic [`DWC_LEN_W-1:0]  m1_cmd_len;
  logic                   beat_valid;
  logic [`DWC_ID_W-1:0]   beat_id;
  logic [`DWC_ADDR_W-1:0] beat_addr;
  logic                   beat_last;

  // test table from the data file
  string   test_name [MAX_TESTS];
  int      test_first [MAX_TESTS];  // index of first command
  int      test_cnt [MAX_TESTS];
  rd_cmd_t cmds [MAX_CMDS];
  int      cmd_port [MAX_CMDS];
  int      cmd_off [MAX_CMDS];      // issue cycle inside the test
  int      cmd_beats [MAX_CMDS];
  int      cmd_final [MAX_CMDS];
  int      n_tests;
  int      n_cmds;
  int      wd_cycles = 0;           // watchdog budget, 0 until loaded

  beat_t beat_q [$];  // everything seen in the current test
  beat_t exp_q [$];   // beat rule for one command
  int    last_cnt;
  int    want_lasts;
  int    idle_cnt;    // holes in the stream mid test
  logic  seen_beat;
  int    test_errs;
  int    pass_cnt = 0;
  int    fail_cnt = 0;

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RST_CYCLES)) clk_gen (
    .ACLK(ACLK), .sysReset(sysReset)
  );

  dwc_rd_top dut (.*);

  ////////////////////////////////////////
  // beat monitor, sampled mid cycle
  ////////////////////////////////////////

  always @(negedge ACLK) begin
    if (sysReset && beat_valid) begin
      beat_q.push_back('{id: beat_id, last: beat_last, addr: beat_addr});
      seen_beat = 1'b1;
      if (beat_last) last_cnt++;
    end else if (sysReset && seen_beat && last_cnt < want_lasts) begin
      idle_cnt++;  // gap while commands still pending
    end
  end

  // budget = reset + per test (beats + 20)
  initial begin
    wait (wd_cycles > 0);
    #(wd_cycles * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", wd_cycles);
    $display("tests failed");
    $finish;
  end

  task automatic load_tests();
    int    fd;
    string line;
    string name;
    int    port;
    int    off;
    int    id;
    int    addr;
    int    mst;
    int    slv;
    int    len;
    int    beats;
    int    fin;
    int    budget;
    n_tests = 0;
    n_cmds  = 0;
    budget  = RST_CYCLES;
    fd = $fopen("dwc_rd_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open dwc_rd_tests.txt");
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() == 0 || line[0] == "#") continue;  // comment or empty
      if ($sscanf(line, "test %s", name) == 1 && n_tests < MAX_TESTS) begin
        test_name[n_tests]  = name;
        test_first[n_tests] = n_cmds;
        test_cnt[n_tests]   = 0;
        n_tests++;
        budget += 20;
      end else if ($sscanf(line, "%d %d %h %h %d %d %d %d %h", port, off, id, addr,
                           mst, slv, len, beats, fin) == 9 && n_tests > 0
                 && n_cmds < MAX_CMDS) begin
        cmds[n_cmds].id       = id[`DWC_ID_W-1:0];
        cmds[n_cmds].addr     = addr[`DWC_ADDR_W-1:0];
        cmds[n_cmds].mst_size = mst[`DWC_SIZE_W-1:0];
        cmds[n_cmds].slv_size = slv[`DWC_SIZE_W-1:0];
        cmds[n_cmds].len      = len[`DWC_LEN_W-1:0];
        cmd_port[n_cmds]  = port;
        cmd_off[n_cmds]   = off;
        cmd_beats[n_cmds] = beats;
        cmd_final[n_cmds] = fin;
        test_cnt[n_tests-1]++;
        budget += beats;
        n_cmds++;
      end
    end
    $fclose(fd);
    wd_cycles = budget;
  endtask

  // one command onto its port for a single cycle
  task automatic drive_cmd(input int i);
    if (cmd_port[i] == 0) begin
      m0_cmd_valid    <= 1'b1;
      m0_cmd_id       <= cmds[i].id;
      m0_cmd_addr     <= cmds[i].addr;
      m0_cmd_mst_size <= cmds[i].mst_size;
      m0_cmd_slv_size <= cmds[i].slv_size;
      m0_cmd_len      <= cmds[i].len;
    end else begin
      m1_cmd_valid    <= 1'b1;
      m1_cmd_id       <= cmds[i].id;
      m1_cmd_addr     <= cmds[i].addr;
      m1_cmd_mst_size <= cmds[i].mst_size;
      m1_cmd_slv_size <= cmds[i].slv_size;
      m1_cmd_len      <= cmds[i].len;
    end
  endtask

  ////////////////////////////////////////
  // reference beat rule
  ////////////////////////////////////////

  task automatic expand_beats(input rd_cmd_t c);
    int eff;
    int msz;    // master beat bytes
    int ssz;    // slave beat bytes
    int a;
    int base;
    int wstart;
    int off;
    eff  = (c.slv_size > c.mst_size) ? c.mst_size : c.slv_size;  // no upsizing
    msz  = 1 << c.mst_size;
    ssz  = 1 << eff;
    a    = c.addr;
    base = a - (a % msz);
    exp_q.delete();
    for (int k = 0; k <= c.len; k++) begin
      wstart = (base + k * msz) % (1 << `DWC_ADDR_W);
      off    = (k == 0) ? (a % msz) - ((a % msz) % ssz) : 0;  // window 0 may start late
      while (off < msz) begin
        exp_q.push_back('{id: c.id, last: (k == c.len) && (off + ssz >= msz),
                          addr: (`DWC_ADDR_W)'(wstart + off)});
        off += ssz;
      end
    end
  endtask

  task automatic run_test(input int t);
    int    first;
    int    max_off;
    int    n_act;
    int    gap;
    logic  done;
    beat_t b;
    beat_t e;
    logic [`DWC_ADDR_W-1:0] last_addr;
    first      = test_first[t];
    test_errs  = 0;
    beat_q.delete();
    last_cnt   = 0;
    idle_cnt   = 0;
    seen_beat  = 1'b0;
    want_lasts = test_cnt[t];
    max_off    = 0;
    for (int i = first; i < first + test_cnt[t]; i++) begin
      if (cmd_off[i] > max_off) max_off = cmd_off[i];
    end
    for (int c = 0; c <= max_off; c++) begin
      @(posedge ACLK);
      m0_cmd_valid <= 1'b0;
      m1_cmd_valid <= 1'b0;
      for (int i = first; i < first + test_cnt[t]; i++) begin
        if (cmd_off[i] == c) drive_cmd(i);
      end
    end
    @(posedge ACLK);
    m0_cmd_valid <= 1'b0;
    m1_cmd_valid <= 1'b0;
    while (last_cnt < want_lasts) @(posedge ACLK);
    // file order is output order
    for (int i = first; i < first + test_cnt[t]; i++) begin
      expand_beats(cmds[i]);
      n_act     = 0;
      done      = 1'b0;
      last_addr = '0;
      while (!done && beat_q.size() > 0) begin
        b = beat_q.pop_front();
        if (b.id != cmds[i].id) begin
          $display("ERROR %s: beat %0d id expected %h actual %h",
                   test_name[t], n_act, cmds[i].id, b.id);
          test_errs++;
        end
        if (n_act < exp_q.size()) begin
          e = exp_q[n_act];
          if (b.addr != e.addr || b.last != e.last) begin
            $display("ERROR %s: id %h beat %0d addr/last expected %h/%b actual %h/%b",
                     test_name[t], cmds[i].id, n_act, e.addr, e.last, b.addr, b.last);
            test_errs++;
          end
        end
        last_addr = b.addr;
        done      = b.last;
        n_act++;
      end
      if (!done) begin
        $display("%s: beats of id %h ran out before beat_last", test_name[t], cmds[i].id);
        test_errs++;
      end
      if (n_act != cmd_beats[i]) begin
        $display("ERROR %s: id %h beat count expected %0d actual %0d",
                 test_name[t], cmds[i].id, cmd_beats[i], n_act);
        test_errs++;
      end
      if (last_addr != cmd_final[i][`DWC_ADDR_W-1:0]) begin
        $display("ERROR %s: id %h final addr expected %h actual %h",
                 test_name[t], cmds[i].id, cmd_final[i][`DWC_ADDR_W-1:0], last_addr);
        test_errs++;
      end
    end
    if (beat_q.size() != 0) begin
      $display("%s: %0d beats left over after the last command", test_name[t], beat_q.size());
      test_errs++;
    end
    if (idle_cnt != 0) begin
      $display("%s: %0d idle cycles inside the beat stream", test_name[t], idle_cnt);
      test_errs++;
    end
    if (test_errs == 0) begin
      $display("test %s: ok, %0d commands", test_name[t], test_cnt[t]);
      pass_cnt++;
    end else begin
      $display("test %s: %0d errors", test_name[t], test_errs);
      fail_cnt++;
    end
    gap = $urandom % 6;  // idle between tests only
    repeat (gap) @(posedge ACLK);
  endtask

  initial begin
    m0_cmd_valid    = 1'b0;
    m0_cmd_id       = '0;
    m0_cmd_addr     = '0;
    m0_cmd_mst_size = '0;
    m0_cmd_slv_size = '0;
    m0_cmd_len      = '0;
    m1_cmd_valid    = 1'b0;
    m1_cmd_id       = '0;
    m1_cmd_addr     = '0;
    m1_cmd_mst_size = '0;
    m1_cmd_slv_size = '0;
    m1_cmd_len      = '0;
    void'($urandom(44));
    load_tests();
    if (n_tests == 0) begin
      $display("no tests could be read from dwc_rd_tests.txt");
      $display("tests failed");
    end else begin
      wait (sysReset === 1'b1);
      @(posedge ACLK);
      for (int t = 0; t < n_tests; t++) run_test(t);
      if (dut.props.fail_cnt != 0) begin
        $display("bound assertions fired %0d times", dut.props.fail_cnt);
      end
      $display("tests run %0d, ok %0d, with errors %0d", n_tests, pass_cnt, fail_cnt);
      if (fail_cnt == 0 && dut.props.fail_cnt == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
    end
    $finish;
  end

endmodule

//--- dwc_rd_props.sv
`timescale 1ns/1ps

module dwc_rd_props (
  input logic ACLK,
  input logic sysReset,
  input logic m0_cmd_valid,
  input logic m1_cmd_valid,
  input logic full0,
  input logic full1,
  input logic beat_valid,
  input logic beat_last
);

  int   fail_cnt = 0;  // failed assertion count
  logic last_seen;     // latest beat closed a command

  // inputs have no back-pressure so a push into a full queue is lost
  no_push_full0: assert property (@(posedge ACLK) disable iff (!sysReset)
    !(m0_cmd_valid && full0))
    else begin
      $error("port 0 command pushed while its FIFO is full");
      fail_cnt++;
    end

  no_push_full1: assert property (@(posedge ACLK) disable iff (!sysReset)
    !(m1_cmd_valid && full1))
    else begin
      $error("port 1 command pushed while its FIFO is full");
      fail_cnt++;
    end

  quiet_in_reset: assert property (@(posedge ACLK) !sysReset |-> !beat_valid)
    else begin
      $error("beat_valid high during reset");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // last beat spacing
  ////////////////////////////////////////

  always_ff @(posedge ACLK or negedge sysReset) begin
    if (!sysReset) begin
      last_seen <= 1'b0;
    end else if (beat_valid) begin
      last_seen <= beat_last;  // idle cycles keep it
    end
  end

  // a plain beat must come between two last beats
  last_spacing: assert property (@(posedge ACLK) disable iff (!sysReset)
    (beat_valid && beat_last) |-> !last_seen)
    else begin
      $error("two beat_last pulses with no beat between them");
      fail_cnt++;
    end

endmodule

bind dwc_rd_top dwc_rd_props props (
  .ACLK(ACLK), .sysReset(sysReset),
  .m0_cmd_valid(m0_cmd_valid), .m1_cmd_valid(m1_cmd_valid),
  .full0(full0), .full1(full1),
  .beat_valid(beat_valid), .beat_last(beat_last)
);

//--- tb_clock.sv
`timescale 1ns/1ps

// free running clock plus power-on reset
module tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic ACLK,
  output logic sysReset
);

  initial begin
    ACLK = 1'b0;
    forever #(PERIOD / 2) ACLK = ~ACLK;
  end

  // active low, released on a rising edge
  initial begin
    sysReset = 1'b0;
    repeat (RESET_CYCLES) @(posedge ACLK);
    sysReset <= 1'b1;
  end

endmodule

//--- dwc_rd_top.sv
`timescale 1ns/1ps
`include "dwc_defines.svh"

module dwc_rd_top import dwc_pkg::*; (
  input  logic                   ACLK,
  input  logic                   sysReset,
  // master port 0
  input  logic                   m0_cmd_valid,
  input  logic [`DWC_ID_W-1:0]   m0_cmd_id,
  input  logic [`DWC_ADDR_W-1:0] m0_cmd_addr,
  input  logic [`DWC_SIZE_W-1:0] m0_cmd_mst_size,
  input  logic [`DWC_SIZE_W-1:0] m0_cmd_slv_size,
  input  logic [`DWC_LEN_W-1:0]  m0_cmd_len,
  // master port 1
  input  logic                   m1_cmd_valid,
  input  logic [`DWC_ID_W-1:0]   m1_cmd_id,
  input  logic [`DWC_ADDR_W-1:0] m1_cmd_addr,
  input  logic [`DWC_SIZE_W-1:0] m1_cmd_mst_size,
  input  logic [`DWC_SIZE_W-1:0] m1_cmd_slv_size,
  input  logic [`DWC_LEN_W-1:0]  m1_cmd_len,
  // narrow beat stream
  output logic                   beat_valid,
  output logic [`DWC_ID_W-1:0]   beat_id,
  output logic [`DWC_ADDR_W-1:0] beat_addr,
  output logic                   beat_last
);

  rd_cmd_t m0_cmd;
  rd_cmd_t m1_cmd;
  rd_cmd_t head0;
  rd_cmd_t head1;
  rd_cmd_t arb_cmd;
  logic    empty0;
  logic    empty1;
  logic    full0;    // watched by bound checks
  logic    full1;
  logic    pop0;
  logic    pop1;
  logic    arb_valid;
  logic    take;

  dwc_hold_if hold_link ();

  // pack port fields into the command struct
  assign m0_cmd = '{id: m0_cmd_id, addr: m0_cmd_addr, mst_size: m0_cmd_mst_size,
                    slv_size: m0_cmd_slv_size, len: m0_cmd_len};
  assign m1_cmd = '{id: m1_cmd_id, addr: m1_cmd_addr, mst_size: m1_cmd_mst_size,
                    slv_size: m1_cmd_slv_size, len: m1_cmd_len};

  ////////////////////////////////////////
  // queues, arbiter, hold, splitter
  ////////////////////////////////////////

  cmd_fifo #(.DEPTH(`DWC_FIFO_DEPTH)) fifo0 (
    .ACLK(ACLK), .sysReset(sysReset),
    .push(m0_cmd_valid), .din(m0_cmd),
    .pop(pop0), .dout(head0), .empty(empty0), .full(full0)
  );

  cmd_fifo #(.DEPTH(`DWC_FIFO_DEPTH)) fifo1 (
    .ACLK(ACLK), .sysReset(sysReset),
    .push(m1_cmd_valid), .din(m1_cmd),
    .pop(pop1), .dout(head1), .empty(empty1), .full(full1)
  );

  cmd_arbiter arb (
    .ACLK(ACLK), .sysReset(sysReset),
    .head0(head0), .empty0(empty0), .head1(head1), .empty1(empty1),
    .take(take), .pop0(pop0), .pop1(pop1),
    .cmd_valid(arb_valid), .cmd(arb_cmd)
  );

  dwc_hold_reg hold_reg (
    .ACLK(ACLK), .sysReset(sysReset),
    .cmd_valid(arb_valid), .cmd(arb_cmd), .take(take),
    .hold(hold_link.hold)
  );

  beat_splitter splitter (
    .ACLK(ACLK), .sysReset(sysReset),
    .hold(hold_link.split),
    .beat_valid(beat_valid), .beat_id(beat_id),
    .beat_addr(beat_addr), .beat_last(beat_last)
  );

endmodule

//--- beat_splitter.sv
`timescale 1ns/1ps
`include "dwc_defines.svh"

module beat_splitter (
  input  logic                   ACLK,
  input  logic                   sysReset,
  dwc_hold_if.split              hold,
  output logic                   beat_valid,
  output logic [`DWC_ID_W-1:0]   beat_id,
  output logic [`DWC_ADDR_W-1:0] beat_addr,
  output logic                   beat_last
);

  logic                   started;   // past first beat of held cmd
  logic [`DWC_ADDR_W-1:0] cur_addr;
  logic [`DWC_ADDR_W-1:0] win_end;   // top byte of current master window
  logic [`DWC_LEN_W-1:0]  beat_cnt;  // master beat index
  logic [`DWC_ADDR_W-1:0] addr_now;
  logic [`DWC_ADDR_W-1:0] end_now;
  logic [`DWC_LEN_W-1:0]  cnt_now;
  logic [`DWC_ADDR_W-1:0] slv_mask;
  logic [`DWC_ADDR_W-1:0] next_win;  // start of the following window
  logic                   last_in_win;

  ////////////////////////////////////////
  // current beat, straight from hold on the first one
  ////////////////////////////////////////

  assign addr_now    = started ? cur_addr : hold.dec.first_addr;
  assign end_now     = started ? win_end  : hold.dec.mst_end;
  assign cnt_now     = started ? beat_cnt : '0;
  assign slv_mask    = hold.dec.slv_step[`DWC_ADDR_W-1:0] - 1'b1;
  assign next_win    = end_now + 1'b1;  // wraps in 6 bits
  assign last_in_win = ((addr_now | slv_mask) == end_now);

  assign beat_valid     = hold.hold_valid;
  assign beat_id        = hold.cmd.id;
  assign beat_addr      = addr_now;
  assign beat_last      = hold.hold_valid && last_in_win && (cnt_now == hold.cmd.len);
  assign hold.get_next  = beat_last;  // release hold with the final beat

  always_ff @(posedge ACLK or negedge sysReset) begin
    if (!sysReset) begin
      started  <= 1'b0;
      cur_addr <= '0;
      win_end  <= '0;
      beat_cnt <= '0;
    end else if (beat_last) begin
      started <= 1'b0;  // next cmd starts from dec
    end else if (hold.hold_valid) begin
      started <= 1'b1;
      if (last_in_win) begin
        cur_addr <= next_win;                      // jump to next window
        win_end  <= next_win + hold.dec.mst_mask;
        beat_cnt <= cnt_now + 1'b1;
      end else begin
        cur_addr <= addr_now + hold.dec.slv_step[`DWC_ADDR_W-1:0];
        win_end  <= end_now;
        beat_cnt <= cnt_now;
      end
    end
  end

endmodule

//--- dwc_hold_reg.sv
`timescale 1ns/1ps
`include "dwc_defines.svh"

module dwc_hold_reg import dwc_pkg::*; (
  input  logic      ACLK,
  input  logic      sysReset,
  input  logic      cmd_valid,  // arbiter offers a command
  input  rd_cmd_t   cmd,
  output logic      take,       // load strobe back to arbiter
  dwc_hold_if.hold  hold
);

  logic [`DWC_SIZE_W-1:0] eff_slv;   // slave size clamped to master
  logic [`DWC_ADDR_W:0]   mst_span;  // master beat bytes, one-hot
  logic [`DWC_ADDR_W-1:0] slv_mask;  // low bits inside a slave beat
  hold_dec_t              dec_d;

  ////////////////////////////////////////
  // load control
  ////////////////////////////////////////

  // empty, or the splitter releases this cycle
  assign take = cmd_valid && (!hold.hold_valid || hold.get_next);

  always_ff @(posedge ACLK or negedge sysReset) begin
    if (!sysReset) begin
      hold.hold_valid <= 1'b0;
    end else if (take) begin
      hold.hold_valid <= 1'b1;   // back to back load
    end else if (hold.get_next) begin
      hold.hold_valid <= 1'b0;   // drained, nothing queued
    end
  end

  ////////////////////////////////////////
  // decode ahead of the splitter
  ////////////////////////////////////////

  always_comb begin
    if (cmd.slv_size > cmd.mst_size) begin
      eff_slv = cmd.mst_size;  // no upsizing here
    end else begin
      eff_slv = cmd.slv_size;
    end
    mst_span       = (`DWC_ADDR_W+1)'(1) << cmd.mst_size;
    dec_d.slv_step = (`DWC_ADDR_W+1)'(1) << eff_slv;
    // size 6 wraps to zero, minus one gives all ones
    dec_d.mst_mask = mst_span[`DWC_ADDR_W-1:0] - 1'b1;
    slv_mask       = dec_d.slv_step[`DWC_ADDR_W-1:0] - 1'b1;

    dec_d.first_addr = cmd.addr & ~slv_mask;
    dec_d.mst_base   = cmd.addr & ~dec_d.mst_mask;
    dec_d.mst_end    = dec_d.mst_base | dec_d.mst_mask;  // top byte of window 0
  end

  // payload, qualified by hold_valid
  always_ff @(posedge ACLK) begin
    if (take) begin
      hold.cmd <= cmd;
      hold.dec <= dec_d;
    end
  end

endmodule

//--- cmd_arbiter.sv
`timescale 1ns/1ps

module cmd_arbiter import dwc_pkg::*; (
  input  logic    ACLK,
  input  logic    sysReset,
  input  rd_cmd_t head0,      // port 0 queue head
  input  logic    empty0,
  input  rd_cmd_t head1,      // port 1 queue head
  input  logic    empty1,
  input  logic    take,       // holding register loads cmd this edge
  output logic    pop0,
  output logic    pop1,
  output logic    cmd_valid,
  output rd_cmd_t cmd
);

  logic grant_ptr;  // favoured port when both queues wait
  logic sel;        // 0 -> port 0, 1 -> port 1

  ////////////////////////////////////////
  // port choice
  ////////////////////////////////////////

  always_comb begin
    if (!empty0 && !empty1) begin
      sel = grant_ptr;  // contention, pointer decides
    end else begin
      sel = empty0;     // lone non-empty port, or don't care
    end
  end

  assign cmd_valid = !(empty0 && empty1);
  assign cmd       = sel ? head1 : head0;

  // pop the winner in the same cycle as take
  assign pop0 = take && !sel;
  assign pop1 = take && sel;

  // flip away from the port just served
  always_ff @(posedge ACLK or negedge sysReset) begin
    if (!sysReset) begin
      grant_ptr <= 1'b0;  // port 0 first
    end else if (take) begin
      grant_ptr <= !sel;
    end
  end

endmodule

//--- cmd_fifo.sv
`timescale 1ns/1ps
`include "dwc_defines.svh"

module cmd_fifo import dwc_pkg::*; #(
  parameter int DEPTH = `DWC_FIFO_DEPTH
) (
  input  logic    ACLK,
  input  logic    sysReset,
  input  logic    push,   // one-cycle write strobe
  input  rd_cmd_t din,
  input  logic    pop,    // one-cycle read strobe
  output rd_cmd_t dout,   // head, shown without a pop
  output logic    empty,
  output logic    full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  rd_cmd_t          mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;  // occupancy
  logic             do_push;
  logic             do_pop;

  // wrap at DEPTH, not only at powers of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_push = push && (!full || pop);  // pop frees the slot this cycle
  assign do_pop  = pop && !empty;
  assign dout    = mem[rd_ptr];

  always_ff @(posedge ACLK or negedge sysReset) begin
    if (!sysReset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // storage, payload only
  always_ff @(posedge ACLK) begin
    if (do_push) mem[wr_ptr] <= din;
  end

endmodule

//--- dwc_hold_if.sv
`timescale 1ns/1ps

// link between the holding register and the beat splitter
interface dwc_hold_if import dwc_pkg::*;
  ();

  logic      hold_valid;  // register holds a command
  rd_cmd_t   cmd;         // raw command fields
  hold_dec_t dec;         // precomputed address fields
  logic      get_next;    // splitter done with held command

  // holding register side
  modport hold (
    output hold_valid,
    output cmd,
    output dec,
    input  get_next
  );

  // splitter side
  modport split (
    input  hold_valid,
    input  cmd,
    input  dec,
    output get_next
  );

endinterface

//--- dwc_pkg.sv
`include "dwc_defines.svh"

package dwc_pkg;

  // read command as issued by a master port
  typedef struct packed {
    logic [`DWC_ID_W-1:0]   id;        // carried through to every beat
    logic [`DWC_ADDR_W-1:0] addr;      // start byte, may be unaligned
    logic [`DWC_SIZE_W-1:0] mst_size;  // wide side beat size
    logic [`DWC_SIZE_W-1:0] slv_size;  // narrow side beat size
    logic [`DWC_LEN_W-1:0]  len;       // master beats minus one
  } rd_cmd_t;

  ////////////////////////////////////////
  // fields decoded once at hold load
  ////////////////////////////////////////

  // slave size already clamped to master size
  typedef struct packed {
    logic [`DWC_ADDR_W:0]   slv_step;    // one-hot slave beat bytes
    logic [`DWC_ADDR_W-1:0] mst_mask;    // low bits inside a master beat
    logic [`DWC_ADDR_W-1:0] first_addr;  // start aligned to slave size
    logic [`DWC_ADDR_W-1:0] mst_base;    // start aligned to master size
    logic [`DWC_ADDR_W-1:0] mst_end;     // last byte of window 0
  } hold_dec_t;

endpackage

//--- dwc_defines.svh
`ifndef DWC_DEFINES_SVH
`define DWC_DEFINES_SVH

// byte address inside the 64 byte window
`define DWC_ADDR_W      6

// transaction id
`define DWC_ID_W        4

// beat size code, bytes = 2**size
`define DWC_SIZE_W      3

// burst length, master beats minus one
`define DWC_LEN_W       4

// entries per port queue
`define DWC_FIFO_DEPTH  4

`endif
